//--- Makefile
# Verilator build and run for the RSA exponentiation engine

VERILATOR ?= verilator
TOP       ?= rsa_core_tb
LINT_TOP  ?= rsa_core
FLIST     ?= rsa_core.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# the log decides, the exit status of the binary is not trusted alone
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "run did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(LINT_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rsa_core.f
+incdir+verilog
verilog/rsa_arith_pkg.sv
verilog/rsa_ctrl_pkg.sv
verilog/rsa_mont_if.sv
verilog/rsa_key_regs.sv
verilog/rsa_prep.sv
verilog/rsa_mont.sv
verilog/rsa_exp_ctrl.sv
verilog/rsa_core.sv
verification/rsa_core_assertions.sv
verification/rsa_core_tb.sv

//--- verification/rsa_core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_core_assertions (
    input logic i_start,
    input logic i_rst,
    input logic i_done,
    input logic i_reject,
    input logic i_busy
);

    a_done_pulse: assert property (@(posedge i_start) disable iff (i_rst)
        i_done |=> !i_done)
        else $error("o_done held for more than one cycle");

    a_reject_pulse: assert property (@(posedge i_start) disable iff (i_rst)
        i_reject |=> !i_reject)
        else $error("o_reject held for more than one cycle");

    // done closes a busy period, so busy was high the cycle before
    a_done_in_busy: assert property (@(posedge i_start) disable iff (i_rst)
        i_done |-> $past(i_busy))
        else $error("o_done outside a busy period");

    a_busy_drop: assert property (@(posedge i_start) disable iff (i_rst)
        i_done |-> !i_busy)
        else $error("o_busy still high with o_done");

    a_busy_fall: assert property (@(posedge i_start) disable iff (i_rst)
        $fell(i_busy) |-> i_done)
        else $error("o_busy fell without o_done");

endmodule

`default_nettype wire

//--- verification/rsa_core_tb.sv
`include "rsa_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module rsa_core_tb;

    // six random runs, two edge exponents, one busy reject, two key loads
    localparam int NUM_VEC   = 11;
    localparam int MAX_CYCLE = (NUM_VEC + 2) * (`RSA_BITS + 2) * (`RSA_BITS + 4);

    typedef logic [2*`RSA_BITS-1:0] dword_t;

    logic                     clk;
    logic                     rst;
    logic                     key_load;
    rsa_arith_pkg::rsa_word_t key_n;
    rsa_arith_pkg::rsa_word_t key_d;
    logic                     valid;
    rsa_arith_pkg::rsa_word_t y_in;
    rsa_arith_pkg::rsa_word_t result;
    logic                     done;
    logic                     reject;
    logic                     busy;

    integer                   seed;
    int                       cycle_cnt = 0;
    rsa_arith_pkg::rsa_word_t n_a;
    rsa_arith_pkg::rsa_word_t d_a;
    rsa_arith_pkg::rsa_word_t n_b;
    rsa_arith_pkg::rsa_word_t d_b;
    rsa_arith_pkg::rsa_word_t y_v;

    rsa_core dut_i (
        .i_start    (clk),
        .i_rst      (rst),
        .i_key_load (key_load),
        .i_n        (key_n),
        .i_d        (key_d),
        .i_valid    (valid),
        .i_y        (y_in),
        .o_result   (result),
        .o_done     (done),
        .o_reject   (reject),
        .o_busy     (busy)
    );

    bind rsa_core rsa_core_assertions u_assert (
        .i_start  (i_start),
        .i_rst    (i_rst),
        .i_done   (o_done),
        .i_reject (o_reject),
        .i_busy   (o_busy)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLE) begin
            $display("timeout: no result from the DUT after %0d cycles", cycle_cnt);
            $display("SIMULATION FAILED");
            $fatal(1, "watchdog expired");
        end
    end

    function automatic rsa_arith_pkg::rsa_word_t rand_word();
        rsa_arith_pkg::rsa_word_t w;
        w = '0;
        for (int i = 0; i < (`RSA_BITS + 31) / 32; i++) begin
            w = (w << 32) | rsa_arith_pkg::rsa_word_t'($unsigned($random(seed)));
        end
        return w;
    endfunction

    // odd with the top bit set
    function automatic rsa_arith_pkg::rsa_word_t rand_modulus();
        rsa_arith_pkg::rsa_word_t w;
        w = rand_word();
        w[`RSA_BITS-1] = 1'b1;
        w[0] = 1'b1;
        return w;
    endfunction

    // reference square-and-multiply on double-width products
    function automatic rsa_arith_pkg::rsa_word_t mod_exp(rsa_arith_pkg::rsa_word_t base_v,
                                                         rsa_arith_pkg::rsa_word_t exp_v,
                                                         rsa_arith_pkg::rsa_word_t mod_v);
        dword_t r;
        dword_t b;
        dword_t m;
        m = dword_t'(mod_v);
        b = dword_t'(base_v) % m;
        r = '0;
        r[0] = 1'b1;
        for (int i = 0; i < `RSA_BITS; i++) begin
            if (exp_v[i]) begin
                r = (r * b) % m;
            end
            b = (b * b) % m;
        end
        return rsa_arith_pkg::rsa_word_t'(r);
    endfunction

    task automatic check_result(input string name, input rsa_arith_pkg::rsa_word_t exp_v,
                                input rsa_arith_pkg::rsa_word_t act_v);
        if (act_v !== exp_v) begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
            $display("SIMULATION FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_flag(input string name, input bit exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, exp_v, act_v);
            $display("SIMULATION FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic load_key(input rsa_arith_pkg::rsa_word_t n, input rsa_arith_pkg::rsa_word_t d);
        @(posedge clk);
        #1;
        key_load = 1'b1;
        key_n    = n;
        key_d    = d;
        @(posedge clk);
        #1;
        key_load = 1'b0;
    endtask

    task automatic pulse_valid(input rsa_arith_pkg::rsa_word_t y);
        @(posedge clk);
        #1;
        valid = 1'b1;
        y_in  = y;
        @(posedge clk);
        #1;
        valid = 1'b0;
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (!done) begin
            @(negedge clk);
        end
    endtask

    // start one exponentiation, then check the result on o_done
    task automatic run_check(input rsa_arith_pkg::rsa_word_t y,
                             input rsa_arith_pkg::rsa_word_t exp_v);
        pulse_valid(y);
        @(negedge clk);
        check_flag("o_busy", 1'b1, busy);
        wait_done();
        check_result("o_result", exp_v, result);
        check_flag("o_busy", 1'b0, busy);
        check_flag("o_reject", 1'b0, reject);
    endtask

    initial begin
        seed     = 92295;
        rst      = 1'b1;
        key_load = 1'b0;
        key_n    = '0;
        key_d    = '0;
        valid    = 1'b0;
        y_in     = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        @(negedge clk);
        check_flag("o_busy", 1'b0, busy);
        check_flag("o_done", 1'b0, done);
        check_flag("o_reject", 1'b0, reject);

        // no key loaded yet
        pulse_valid(rand_word());
        @(negedge clk);
        check_flag("o_reject", 1'b1, reject);
        check_flag("o_busy", 1'b0, busy);
        check_flag("o_done", 1'b0, done);
        @(negedge clk);
        check_flag("o_reject", 1'b0, reject);
        check_flag("o_done", 1'b0, done);

        for (int v = 0; v < 6; v++) begin
            n_a = rand_modulus();
            d_a = rand_word();
            y_v = rand_word() % n_a;
            load_key(n_a, d_a);
            run_check(y_v, mod_exp(y_v, d_a, n_a));
        end

        // edge exponents
        n_a = rand_modulus();
        y_v = rand_word() % n_a;
        load_key(n_a, '0);
        run_check(y_v, rsa_arith_pkg::rsa_word_t'(1));
        load_key(n_a, rsa_arith_pkg::rsa_word_t'(1));
        run_check(y_v, y_v);

        // request while busy is dropped
        d_a = rand_word();
        load_key(n_a, d_a);
        pulse_valid(y_v);
        repeat (40) @(posedge clk);
        pulse_valid(rand_word() % n_a);
        @(negedge clk);
        check_flag("o_reject", 1'b1, reject);
        check_flag("o_busy", 1'b1, busy);
        wait_done();
        check_result("o_result", mod_exp(y_v, d_a, n_a), result);

        // key load while busy is ignored, a later one takes effect
        n_b = rand_modulus();
        d_b = rand_word();
        y_v = rand_word() % ((n_a < n_b) ? n_a : n_b);
        pulse_valid(y_v);
        repeat (30) @(posedge clk);
        load_key(n_b, d_b);
        wait_done();
        check_result("o_result", mod_exp(y_v, d_a, n_a), result);
        load_key(n_b, d_b);
        run_check(y_v, mod_exp(y_v, d_b, n_b));

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/rsa_arith_pkg.sv
`include "rsa_cfg.svh"

`default_nettype none

package rsa_arith_pkg;

    // one operand or modulus
    typedef logic [`RSA_BITS-1:0] rsa_word_t;

    // guard bits hold a doubled value or a Montgomery partial sum
    typedef logic [`RSA_BITS+2:0] rsa_ext_t;

    // round and bit index counter
    typedef logic [`RSA_CNT_W-1:0] rsa_cnt_t;

endpackage

`default_nettype wire

//--- verilog/rsa_cfg.svh
`ifndef RSA_CFG_SVH
`define RSA_CFG_SVH

`default_nettype none

// operand width in bits, 64 also works for quick runs
`define RSA_BITS 256

// iteration counter, wide enough to hold RSA_BITS itself
`define RSA_CNT_W 9

`default_nettype wire

`endif

//--- verilog/rsa_core.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_core (
    input  logic                     i_start,
    input  logic                     i_rst,
    input  logic                     i_key_load,
    input  rsa_arith_pkg::rsa_word_t i_n,
    input  rsa_arith_pkg::rsa_word_t i_d,
    input  logic                     i_valid,
    input  rsa_arith_pkg::rsa_word_t i_y,
    output rsa_arith_pkg::rsa_word_t o_result,
    output logic                     o_done,
    output logic                     o_reject,
    output logic                     o_busy
);

    rsa_arith_pkg::rsa_word_t key_n;
    rsa_arith_pkg::rsa_word_t key_d;
    rsa_arith_pkg::rsa_word_t prep_val;
    logic                     key_ready;
    logic                     prep_go;
    logic                     prep_done;
    logic                     busy;

    rsa_mont_if sq_if ();
    rsa_mont_if acc_if ();

    rsa_key_regs u_key (
        .i_start     (i_start),
        .i_rst       (i_rst),
        .i_key_load  (i_key_load),
        .i_n         (i_n),
        .i_d         (i_d),
        .i_busy      (busy),
        .o_n         (key_n),
        .o_d         (key_d),
        .o_key_ready (key_ready)
    );

    // y is sampled on the accept cycle
    rsa_prep u_prep (
        .i_start (i_start),
        .i_rst   (i_rst),
        .i_go    (prep_go),
        .i_y     (i_y),
        .i_n     (key_n),
        .o_prep  (prep_val),
        .o_done  (prep_done)
    );

    rsa_exp_ctrl u_ctrl (
        .i_start     (i_start),
        .i_rst       (i_rst),
        .i_valid     (i_valid),
        .i_y         (i_y),
        .i_n         (key_n),
        .i_d         (key_d),
        .i_key_ready (key_ready),
        .o_prep_go   (prep_go),
        .i_prep      (prep_val),
        .i_prep_done (prep_done),
        .sq          (sq_if.master),
        .acc         (acc_if.master),
        .o_busy      (busy),
        .o_done      (o_done),
        .o_reject    (o_reject),
        .o_result    (o_result)
    );

    rsa_mont u_sq (
        .i_start (i_start),
        .i_rst   (i_rst),
        .mont    (sq_if.unit)
    );

    rsa_mont u_acc (
        .i_start (i_start),
        .i_rst   (i_rst),
        .mont    (acc_if.unit)
    );

    assign o_busy = busy;

endmodule

`default_nettype wire

//--- verilog/rsa_ctrl_pkg.sv
`default_nettype none

package rsa_ctrl_pkg;

    // exponentiation sequencer
    typedef enum logic [1:0] {
        S_IDLE,
        S_PREP,
        S_MULT,
        S_STEP
    } exp_state_e;

    // prep and Montgomery multiplier
    typedef enum logic {
        U_IDLE,
        U_RUN
    } unit_state_e;

endpackage

`default_nettype wire

//--- verilog/rsa_exp_ctrl.sv
`include "rsa_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module rsa_exp_ctrl (
    input  logic                     i_start,
    input  logic                     i_rst,
    input  logic                     i_valid,
    input  rsa_arith_pkg::rsa_word_t i_y,
    input  rsa_arith_pkg::rsa_word_t i_n,
    input  rsa_arith_pkg::rsa_word_t i_d,
    input  logic                     i_key_ready,
    output logic                     o_prep_go,
    input  rsa_arith_pkg::rsa_word_t i_prep,
    input  logic                     i_prep_done,
    rsa_mont_if.master               sq,
    rsa_mont_if.master               acc,
    output logic                     o_busy,
    output logic                     o_done,
    output logic                     o_reject,
    output rsa_arith_pkg::rsa_word_t o_result
);

    localparam int IDX_W = $clog2(`RSA_BITS);

    rsa_ctrl_pkg::exp_state_e state_r;
    rsa_arith_pkg::rsa_cnt_t  cnt_r;
    rsa_arith_pkg::rsa_cnt_t  nxt_cnt;
    rsa_arith_pkg::rsa_word_t t_r;
    rsa_arith_pkg::rsa_word_t m_r;
    logic                     accept;
    logic                     last;
    logic                     nxt_acc;
    logic                     round_go;
    logic                     round_end;
    logic                     sq_start_r;
    logic                     acc_start_r;
    logic                     acc_run_r;
    logic                     sq_seen_r;
    logic                     acc_seen_r;
    logic                     done_r;
    logic                     reject_r;

    assign accept    = (state_r == rsa_ctrl_pkg::S_IDLE) && i_valid && i_key_ready;
    assign o_prep_go = accept;
    assign last      = (cnt_r == rsa_arith_pkg::rsa_cnt_t'(`RSA_BITS - 1));

    // prep is followed by round 0, a step by the next round
    assign nxt_cnt  = (state_r == rsa_ctrl_pkg::S_PREP) ? '0 : cnt_r + 1'b1;
    // bit 0 is already folded into m at accept
    assign nxt_acc  = i_d[nxt_cnt[IDX_W-1:0]] && (nxt_cnt != '0);
    assign round_go = (state_r == rsa_ctrl_pkg::S_PREP && i_prep_done) ||
                      (state_r == rsa_ctrl_pkg::S_STEP && !last);

    // wait only for the multipliers started this round
    assign round_end = (sq_seen_r || sq.done) &&
                       (!acc_run_r || acc_seen_r || acc.done);

    always_ff @(posedge i_start or posedge i_rst) begin
        if (i_rst) begin
            state_r     <= rsa_ctrl_pkg::S_IDLE;
            cnt_r       <= '0;
            sq_start_r  <= 1'b0;
            acc_start_r <= 1'b0;
            acc_run_r   <= 1'b0;
            sq_seen_r   <= 1'b0;
            acc_seen_r  <= 1'b0;
            done_r      <= 1'b0;
            reject_r    <= 1'b0;
        end else begin
            sq_start_r  <= 1'b0;
            acc_start_r <= 1'b0;
            done_r      <= 1'b0;
            reject_r    <= i_valid && !accept;
            case (state_r)
                rsa_ctrl_pkg::S_IDLE: begin
                    if (accept) begin
                        state_r <= rsa_ctrl_pkg::S_PREP;
                    end
                end
                rsa_ctrl_pkg::S_PREP: begin
                    if (i_prep_done) begin
                        state_r <= rsa_ctrl_pkg::S_MULT;
                    end
                end
                rsa_ctrl_pkg::S_MULT: begin
                    if (sq.done) begin
                        sq_seen_r <= 1'b1;
                    end
                    if (acc.done) begin
                        acc_seen_r <= 1'b1;
                    end
                    if (round_end) begin
                        state_r <= rsa_ctrl_pkg::S_STEP;
                    end
                end
                rsa_ctrl_pkg::S_STEP: begin
                    if (last) begin
                        state_r <= rsa_ctrl_pkg::S_IDLE;
                        done_r  <= 1'b1;
                    end else begin
                        state_r <= rsa_ctrl_pkg::S_MULT;
                    end
                end
                default: state_r <= rsa_ctrl_pkg::S_IDLE;
            endcase
            if (round_go) begin
                cnt_r       <= nxt_cnt;
                sq_start_r  <= 1'b1;
                acc_start_r <= nxt_acc;
                acc_run_r   <= nxt_acc;
                sq_seen_r   <= 1'b0;
                acc_seen_r  <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_start) begin
        if (accept) begin
            // 1 times y needs no multiply
            m_r <= i_d[0] ? i_y : rsa_arith_pkg::rsa_word_t'(1);
        end
        if (state_r == rsa_ctrl_pkg::S_PREP && i_prep_done) begin
            t_r <= i_prep;
        end
        if (state_r == rsa_ctrl_pkg::S_STEP) begin
            t_r <= sq.result;
            if (acc_run_r) begin
                m_r <= acc.result;
            end
        end
    end

    // t squares in Montgomery form, m absorbs the R^-1 and stays ordinary
    assign sq.start  = sq_start_r;
    assign sq.a      = t_r;
    assign sq.b      = t_r;
    assign sq.n      = i_n;
    assign acc.start = acc_start_r;
    assign acc.a     = m_r;
    assign acc.b     = t_r;
    assign acc.n     = i_n;

    assign o_busy   = (state_r != rsa_ctrl_pkg::S_IDLE);
    assign o_done   = done_r;
    assign o_reject = reject_r;
    assign o_result = m_r;

endmodule

`default_nettype wire

//--- verilog/rsa_key_regs.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_key_regs (
    input  logic                     i_start,
    input  logic                     i_rst,
    input  logic                     i_key_load,
    input  rsa_arith_pkg::rsa_word_t i_n,
    input  rsa_arith_pkg::rsa_word_t i_d,
    input  logic                     i_busy,
    output rsa_arith_pkg::rsa_word_t o_n,
    output rsa_arith_pkg::rsa_word_t o_d,
    output logic                     o_key_ready
);

    rsa_arith_pkg::rsa_word_t n_r;
    rsa_arith_pkg::rsa_word_t d_r;
    logic                     ready_r;
    logic                     load_ok;

    // a running exponentiation keeps the key it started with
    assign load_ok = i_key_load && !i_busy;

    always_ff @(posedge i_start or posedge i_rst) begin
        if (i_rst) begin
            ready_r <= 1'b0;
        end else if (load_ok) begin
            ready_r <= 1'b1;
        end
    end

    always_ff @(posedge i_start) begin
        if (load_ok) begin
            n_r <= i_n;
            d_r <= i_d;
        end
    end

    assign o_n         = n_r;
    assign o_d         = d_r;
    assign o_key_ready = ready_r;

endmodule

`default_nettype wire

//--- verilog/rsa_mont.sv
`include "rsa_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module rsa_mont (
    input  logic           i_start,
    input  logic           i_rst,
    rsa_mont_if.unit       mont
);

    localparam int IDX_W = $clog2(`RSA_BITS);

    rsa_ctrl_pkg::unit_state_e state_r;
    rsa_arith_pkg::rsa_cnt_t   cnt_r;
    rsa_arith_pkg::rsa_ext_t   acc_r;
    rsa_arith_pkg::rsa_ext_t   acc_nxt;
    rsa_arith_pkg::rsa_ext_t   base;
    rsa_arith_pkg::rsa_ext_t   sum;
    rsa_arith_pkg::rsa_ext_t   res_sub;
    rsa_arith_pkg::rsa_ext_t   n_ext;
    rsa_arith_pkg::rsa_ext_t   b_ext;
    rsa_arith_pkg::rsa_word_t  result_r;
    logic                      a_bit;
    logic                      final_step;
    logic                      done_r;

    assign n_ext      = rsa_arith_pkg::rsa_ext_t'(mont.n);
    assign b_ext      = rsa_arith_pkg::rsa_ext_t'(mont.b);
    assign final_step = (cnt_r == rsa_arith_pkg::rsa_cnt_t'(`RSA_BITS));

    // first iteration runs on the start edge from a zero accumulator
    always_comb begin
        base    = (state_r == rsa_ctrl_pkg::U_RUN) ? acc_r : '0;
        a_bit   = (state_r == rsa_ctrl_pkg::U_RUN) ? mont.a[cnt_r[IDX_W-1:0]] : mont.a[0];
        sum     = base + (a_bit ? b_ext : '0);
        // make the sum even so the halving is exact mod n
        if (sum[0]) begin
            sum = sum + n_ext;
        end
        acc_nxt = sum >> 1;
        res_sub = (acc_r >= n_ext) ? acc_r - n_ext : acc_r;
    end

    always_ff @(posedge i_start or posedge i_rst) begin
        if (i_rst) begin
            state_r <= rsa_ctrl_pkg::U_IDLE;
            cnt_r   <= '0;
            done_r  <= 1'b0;
        end else begin
            done_r <= 1'b0;
            case (state_r)
                rsa_ctrl_pkg::U_IDLE: begin
                    if (mont.start) begin
                        state_r <= rsa_ctrl_pkg::U_RUN;
                        cnt_r   <= rsa_arith_pkg::rsa_cnt_t'(1);
                    end
                end
                rsa_ctrl_pkg::U_RUN: begin
                    if (final_step) begin
                        state_r <= rsa_ctrl_pkg::U_IDLE;
                        done_r  <= 1'b1;
                    end else begin
                        cnt_r <= cnt_r + 1'b1;
                    end
                end
                default: state_r <= rsa_ctrl_pkg::U_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_start) begin
        if (state_r == rsa_ctrl_pkg::U_IDLE && mont.start) begin
            acc_r <= acc_nxt;
        end else if (state_r == rsa_ctrl_pkg::U_RUN) begin
            if (final_step) begin
                // accumulator ends below 2n
                result_r <= res_sub[`RSA_BITS-1:0];
            end else begin
                acc_r <= acc_nxt;
            end
        end
    end

    assign mont.result = result_r;
    assign mont.done   = done_r;

endmodule

`default_nettype wire

//--- verilog/rsa_mont_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rsa_mont_if;

    logic                     start;
    rsa_arith_pkg::rsa_word_t a;
    rsa_arith_pkg::rsa_word_t b;
    rsa_arith_pkg::rsa_word_t n;
    rsa_arith_pkg::rsa_word_t result;
    logic                     done;

    // requester side, operands held until done
    modport master (
        output start, a, b, n,
        input  result, done
    );

    // multiplier side
    modport unit (
        input  start, a, b, n,
        output result, done
    );

endinterface

`default_nettype wire

//--- verilog/rsa_prep.sv
`include "rsa_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module rsa_prep (
    input  logic                     i_start,
    input  logic                     i_rst,
    input  logic                     i_go,
    input  rsa_arith_pkg::rsa_word_t i_y,
    input  rsa_arith_pkg::rsa_word_t i_n,
    output rsa_arith_pkg::rsa_word_t o_prep,
    output logic                     o_done
);

    rsa_ctrl_pkg::unit_state_e state_r;
    rsa_arith_pkg::rsa_cnt_t   cnt_r;
    rsa_arith_pkg::rsa_ext_t   acc_r;
    rsa_arith_pkg::rsa_ext_t   acc_nxt;
    rsa_arith_pkg::rsa_ext_t   n_ext;
    logic                      last;
    logic                      done_r;

    assign n_ext = rsa_arith_pkg::rsa_ext_t'(i_n);
    assign last  = (cnt_r == rsa_arith_pkg::rsa_cnt_t'(`RSA_BITS - 1));

    // value stays below n, so a doubled value needs at most one subtract
    always_comb begin
        acc_nxt = acc_r << 1;
        if (acc_nxt >= n_ext) begin
            acc_nxt = acc_nxt - n_ext;
        end
    end

    always_ff @(posedge i_start or posedge i_rst) begin
        if (i_rst) begin
            state_r <= rsa_ctrl_pkg::U_IDLE;
            cnt_r   <= '0;
            done_r  <= 1'b0;
        end else begin
            done_r <= 1'b0;
            case (state_r)
                rsa_ctrl_pkg::U_IDLE: begin
                    if (i_go) begin
                        state_r <= rsa_ctrl_pkg::U_RUN;
                        cnt_r   <= '0;
                    end
                end
                rsa_ctrl_pkg::U_RUN: begin
                    cnt_r <= cnt_r + 1'b1;
                    if (last) begin
                        state_r <= rsa_ctrl_pkg::U_IDLE;
                        done_r  <= 1'b1;
                    end
                end
                default: state_r <= rsa_ctrl_pkg::U_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_start) begin
        if (state_r == rsa_ctrl_pkg::U_IDLE && i_go) begin
            acc_r <= rsa_arith_pkg::rsa_ext_t'(i_y);
        end else if (state_r == rsa_ctrl_pkg::U_RUN) begin
            acc_r <= acc_nxt;
        end
    end

    // holds after done until the next go reloads y
    assign o_prep = acc_r[`RSA_BITS-1:0];
    assign o_done = done_r;

endmodule

`default_nettype wire
